// File: trans_unit.f
trans_pkg.sv
trans_isa_pkg.sv
trans_decode.sv
trans_core.sv
trans_lane_io.sv
trans_unit.sv
trans_unit_tb.sv

// File: trans_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module trans_unit_tb;

  import trans_pkg::*;
  import trans_isa_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 200;
  localparam int MARGIN      = 4;

  logic                 CLK;
  logic                 RST;
  logic                 instr_valid;
  trans_op_e            instr_op;
  logic [LANE_W-1:0]    instr_a;
  logic [LANE_W-1:0]    instr_b;
  logic [NUM_LANES-1:0] instr_mask;
  logic [DATA_W-1:0]    load_data;
  logic [LANE_W-1:0]    read_lane;
  logic [DATA_W-1:0]    read_data;

  // expected lanes, and the lane values the fans capture from.
  logic [DATA_W-1:0]    model [NUM_LANES];
  logic [DATA_W-1:0]    src [NUM_LANES];

  trans_unit i_dut (
    .CLK         (CLK),
    .RST         (RST),
    .instr_valid (instr_valid),
    .instr_op    (instr_op),
    .instr_a     (instr_a),
    .instr_b     (instr_b),
    .instr_mask  (instr_mask),
    .load_data   (load_data),
    .read_lane   (read_lane),
    .read_data   (read_data)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    if (got !== exp)
    begin
      $display("Error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  // apply one instruction to the model with src as the old lanes.
  task automatic model_exec(input trans_op_e op, input logic [LANE_W-1:0] a,
                            input logic [LANE_W-1:0] b, input logic [NUM_LANES-1:0] mask,
                            input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] acc;
    acc = '0;
    case (op)
      OP_MOVE:
      begin
        for (int i = 0; i < NUM_LANES; i++)
          if (mask[i])
            model[i] = src[a];
      end
      OP_SWAP:
      begin
        model[a] = src[b];
        model[b] = src[a];
      end
      OP_LOAD:
        model[a] = data;
      OP_MERGE:
      begin
        for (int i = 0; i < NUM_LANES; i++)
          if (mask[i])
            acc = acc | src[i];
        model[a] = acc;
      end
      default:
        acc = '0;
    endcase
  endtask

  task automatic drive_instr(input trans_op_e op, input logic [LANE_W-1:0] a,
                             input logic [LANE_W-1:0] b, input logic [NUM_LANES-1:0] mask,
                             input logic [DATA_W-1:0] data);
    @(posedge CLK);
    instr_valid <= 1'b1;
    instr_op    <= op;
    instr_a     <= a;
    instr_b     <= b;
    instr_mask  <= mask;
    load_data   <= data;
  endtask

  // drop the strobe, then wait out the two-cycle latency.
  task automatic finish_instr();
    @(posedge CLK);
    instr_valid <= 1'b0;
    instr_op    <= OP_NOP;
    repeat (2) @(posedge CLK);
  endtask

  task automatic run_one(input trans_op_e op, input logic [LANE_W-1:0] a,
                         input logic [LANE_W-1:0] b, input logic [NUM_LANES-1:0] mask,
                         input logic [DATA_W-1:0] data);
    src = model;
    model_exec(op, a, b, mask, data);
    drive_instr(op, a, b, mask, data);
    finish_instr();
  endtask

  // load then move on consecutive clocks; the move sees the old lane.
  task automatic run_load_move(input logic [LANE_W-1:0] a, input logic [NUM_LANES-1:0] mask,
                               input logic [DATA_W-1:0] data);
    src = model;
    model_exec(OP_LOAD, a, '0, '0, data);
    model_exec(OP_MOVE, a, '0, mask, '0);
    drive_instr(OP_LOAD, a, '0, '0, data);
    drive_instr(OP_MOVE, a, '0, mask, '0);
    finish_instr();
  endtask

  task automatic verify_all();
    for (int i = 0; i < NUM_LANES; i++)
    begin
      @(posedge CLK);
      read_lane <= LANE_W'(i);
      @(negedge CLK);
      check_value($sformatf("read_data[lane %0d]", i), read_data, model[i]);
    end
  endtask

  task automatic reload_lanes();
    for (int i = 0; i < NUM_LANES; i++)
      run_one(OP_LOAD, LANE_W'(i), '0, '0, $urandom);
  endtask

  task automatic test_move();
    logic [NUM_LANES-1:0] mask;
    for (int k = 0; k < 6; k++)
    begin
      mask = (k == 0) ? '0 : (k == 5) ? '1 : NUM_LANES'($urandom);
      run_one(OP_MOVE, LANE_W'($urandom_range(7)), '0, mask, '0);
      verify_all();
    end
  endtask

  task automatic test_swap();
    logic [LANE_W-1:0] a;
    reload_lanes();
    for (int k = 0; k < 4; k++)
    begin
      a = LANE_W'($urandom_range(7));
      run_one(OP_SWAP, a, a + LANE_W'(1 + $urandom_range(6)), '0, '0);
      verify_all();
    end
    a = LANE_W'($urandom_range(7));
    run_one(OP_SWAP, a, a, '0, '0);
    verify_all();
  endtask

  task automatic test_merge();
    logic [NUM_LANES-1:0] mask;
    reload_lanes();
    for (int k = 0; k < 5; k++)
    begin
      mask = (k == 0) ? '0 : (k == 4) ? '1 : NUM_LANES'($urandom);
      run_one(OP_MERGE, LANE_W'($urandom_range(7)), '0, mask, '0);
      verify_all();
    end
  endtask

  task automatic test_back_to_back();
    logic [LANE_W-1:0] a;
    reload_lanes();
    a = LANE_W'($urandom_range(7));
    run_load_move(a, NUM_LANES'($urandom) & ~(NUM_LANES'(1) << a), $urandom);
    verify_all();
    // mask covers the source, so the load is overwritten.
    a = LANE_W'($urandom_range(7));
    run_load_move(a, NUM_LANES'($urandom) | (NUM_LANES'(1) << a), $urandom);
    verify_all();
  endtask

  initial
  begin
    #(NUM_TESTS * TEST_CYCLES * MARGIN * CLK_PERIOD);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    CLK         = 1'b0;
    RST         = 1'b0;
    instr_valid = 1'b0;
    instr_op    = OP_NOP;
    instr_a     = '0;
    instr_b     = '0;
    instr_mask  = '0;
    load_data   = '0;
    read_lane   = '0;
    void'($urandom(94));
    for (int i = 0; i < NUM_LANES; i++)
      model[i] = '0;
    repeat (5) @(posedge CLK);
    RST <= 1'b1;

    verify_all();
    reload_lanes();
    verify_all();
    test_move();
    test_swap();
    test_merge();
    test_back_to_back();

    @(posedge CLK);
    $display("Done: no errors");
    $finish;
  end

endmodule : trans_unit_tb

`default_nettype wire

// File: trans_unit.sv
`timescale 1ns/1ps
`default_nettype none

module trans_unit (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           instr_valid,
  input  trans_isa_pkg::trans_op_e       instr_op,
  input  logic [trans_pkg::LANE_W-1:0]    instr_a,
  input  logic [trans_pkg::LANE_W-1:0]    instr_b,
  input  logic [trans_pkg::NUM_LANES-1:0] instr_mask,
  input  logic [trans_pkg::DATA_W-1:0]    load_data,
  input  logic [trans_pkg::LANE_W-1:0]    read_lane,
  output logic [trans_pkg::DATA_W-1:0]    read_data
);

  import trans_pkg::*;

  logic [SEL_W-1:0]  isel;
  logic [SEL_W-1:0]  osel;
  logic              load_en;
  logic [LANE_W-1:0] load_lane;
  logic [DATA_W-1:0] load_word;

  logic [DATA_W-1:0] in_0;
  logic [DATA_W-1:0] in_1;
  logic [DATA_W-1:0] in_2;
  logic [DATA_W-1:0] in_3;
  logic [DATA_W-1:0] in_4;
  logic [DATA_W-1:0] in_5;
  logic [DATA_W-1:0] in_6;
  logic [DATA_W-1:0] in_7;
  logic [DATA_W-1:0] out_0;
  logic [DATA_W-1:0] out_1;
  logic [DATA_W-1:0] out_2;
  logic [DATA_W-1:0] out_3;
  logic [DATA_W-1:0] out_4;
  logic [DATA_W-1:0] out_5;
  logic [DATA_W-1:0] out_6;
  logic [DATA_W-1:0] out_7;

  trans_decode i_decode (
    .CLK         (CLK),
    .RST         (RST),
    .instr_valid (instr_valid),
    .instr_op    (instr_op),
    .instr_a     (instr_a),
    .instr_b     (instr_b),
    .instr_mask  (instr_mask),
    .load_data   (load_data),
    .isel        (isel),
    .osel        (osel),
    .load_en     (load_en),
    .load_lane   (load_lane),
    .load_word   (load_word)
  );

  // lane registers live in the core; outputs loop back through lane io.
  trans_core i_core (
    .CLK   (CLK),
    .RST   (RST),
    .in_0  (in_0),
    .in_1  (in_1),
    .in_2  (in_2),
    .in_3  (in_3),
    .in_4  (in_4),
    .in_5  (in_5),
    .in_6  (in_6),
    .in_7  (in_7),
    .isel  (isel),
    .osel  (osel),
    .out_0 (out_0),
    .out_1 (out_1),
    .out_2 (out_2),
    .out_3 (out_3),
    .out_4 (out_4),
    .out_5 (out_5),
    .out_6 (out_6),
    .out_7 (out_7)
  );

  trans_lane_io i_lane_io (
    .out_0     (out_0),
    .out_1     (out_1),
    .out_2     (out_2),
    .out_3     (out_3),
    .out_4     (out_4),
    .out_5     (out_5),
    .out_6     (out_6),
    .out_7     (out_7),
    .load_en   (load_en),
    .load_lane (load_lane),
    .load_word (load_word),
    .read_lane (read_lane),
    .in_0      (in_0),
    .in_1      (in_1),
    .in_2      (in_2),
    .in_3      (in_3),
    .in_4      (in_4),
    .in_5      (in_5),
    .in_6      (in_6),
    .in_7      (in_7),
    .read_data (read_data)
  );

endmodule : trans_unit

`default_nettype wire

// File: trans_lane_io.sv
`timescale 1ns/1ps
`default_nettype none

module trans_lane_io (
  input  logic [trans_pkg::DATA_W-1:0] out_0,
  input  logic [trans_pkg::DATA_W-1:0] out_1,
  input  logic [trans_pkg::DATA_W-1:0] out_2,
  input  logic [trans_pkg::DATA_W-1:0] out_3,
  input  logic [trans_pkg::DATA_W-1:0] out_4,
  input  logic [trans_pkg::DATA_W-1:0] out_5,
  input  logic [trans_pkg::DATA_W-1:0] out_6,
  input  logic [trans_pkg::DATA_W-1:0] out_7,
  input  logic                        load_en,
  input  logic [trans_pkg::LANE_W-1:0] load_lane,
  input  logic [trans_pkg::DATA_W-1:0] load_word,
  input  logic [trans_pkg::LANE_W-1:0] read_lane,
  output logic [trans_pkg::DATA_W-1:0] in_0,
  output logic [trans_pkg::DATA_W-1:0] in_1,
  output logic [trans_pkg::DATA_W-1:0] in_2,
  output logic [trans_pkg::DATA_W-1:0] in_3,
  output logic [trans_pkg::DATA_W-1:0] in_4,
  output logic [trans_pkg::DATA_W-1:0] in_5,
  output logic [trans_pkg::DATA_W-1:0] in_6,
  output logic [trans_pkg::DATA_W-1:0] in_7,
  output logic [trans_pkg::DATA_W-1:0] read_data
);

  import trans_pkg::*;

  logic [DATA_W-1:0]    lane_arr [NUM_LANES];
  logic [DATA_W-1:0]    feed_arr [NUM_LANES];
  logic [NUM_LANES-1:0] sub_vec;

  assign lane_arr[0] = out_0;
  assign lane_arr[1] = out_1;
  assign lane_arr[2] = out_2;
  assign lane_arr[3] = out_3;
  assign lane_arr[4] = out_4;
  assign lane_arr[5] = out_5;
  assign lane_arr[6] = out_6;
  assign lane_arr[7] = out_7;

  // feed lanes back, load word in place of the load lane.
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      sub_vec[i]  = load_en && (load_lane == LANE_W'(i));
      feed_arr[i] = sub_vec[i] ? load_word : lane_arr[i];
    end
  end

  assign in_0 = feed_arr[0];
  assign in_1 = feed_arr[1];
  assign in_2 = feed_arr[2];
  assign in_3 = feed_arr[3];
  assign in_4 = feed_arr[4];
  assign in_5 = feed_arr[5];
  assign in_6 = feed_arr[6];
  assign in_7 = feed_arr[7];

  // read port straight from the lane registers.
  assign read_data = lane_arr[read_lane];

  // no clock here, so sample on the unit clock.
  a_one_sub: assert property (@(posedge trans_unit.CLK) disable iff (!trans_unit.RST)
    $onehot0(sub_vec))
    else $error("more than one lane substituted with load data");

endmodule : trans_lane_io

`default_nettype wire

// File: trans_core.sv
`timescale 1ns/1ps
`default_nettype none

module trans_core (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic [trans_pkg::DATA_W-1:0] in_0,
  input  logic [trans_pkg::DATA_W-1:0] in_1,
  input  logic [trans_pkg::DATA_W-1:0] in_2,
  input  logic [trans_pkg::DATA_W-1:0] in_3,
  input  logic [trans_pkg::DATA_W-1:0] in_4,
  input  logic [trans_pkg::DATA_W-1:0] in_5,
  input  logic [trans_pkg::DATA_W-1:0] in_6,
  input  logic [trans_pkg::DATA_W-1:0] in_7,
  input  logic [trans_pkg::SEL_W-1:0]  isel,
  input  logic [trans_pkg::SEL_W-1:0]  osel,
  output logic [trans_pkg::DATA_W-1:0] out_0,
  output logic [trans_pkg::DATA_W-1:0] out_1,
  output logic [trans_pkg::DATA_W-1:0] out_2,
  output logic [trans_pkg::DATA_W-1:0] out_3,
  output logic [trans_pkg::DATA_W-1:0] out_4,
  output logic [trans_pkg::DATA_W-1:0] out_5,
  output logic [trans_pkg::DATA_W-1:0] out_6,
  output logic [trans_pkg::DATA_W-1:0] out_7
);

  import trans_pkg::*;

  logic [DATA_W-1:0]    in_arr [NUM_LANES];
  logic [DATA_W-1:0]    lane_q [NUM_LANES];
  logic [DATA_W-1:0]    fan_0;
  logic [DATA_W-1:0]    fan_1;
  logic [DATA_W-1:0]    fan_or_0;
  logic [DATA_W-1:0]    fan_or_1;
  logic [NUM_LANES-1:0] wr_en;
  logic [NUM_LANES-1:0] pick_0;

  assign in_arr[0] = in_0;
  assign in_arr[1] = in_1;
  assign in_arr[2] = in_2;
  assign in_arr[3] = in_3;
  assign in_arr[4] = in_4;
  assign in_arr[5] = in_5;
  assign in_arr[6] = in_6;
  assign in_arr[7] = in_7;

  assign wr_en  = osel[NUM_LANES-1:0];
  assign pick_0 = osel[SEL_W-1:NUM_LANES];

  // each fan is the OR of its enabled lanes.
  always_comb
  begin
    fan_or_0 = '0;
    fan_or_1 = '0;
    for (int i = 0; i < NUM_LANES; i++)
    begin
      fan_or_0 = fan_or_0 | ({DATA_W{isel[i]}} & in_arr[i]);
      fan_or_1 = fan_or_1 | ({DATA_W{isel[NUM_LANES + i]}} & in_arr[i]);
    end
  end

  // fans capture every cycle; lanes only when enabled.
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      fan_0 <= '0;
      fan_1 <= '0;
      for (int i = 0; i < NUM_LANES; i++)
        lane_q[i] <= '0;
    end
    else
    begin
      fan_0 <= fan_or_0;
      fan_1 <= fan_or_1;
      for (int i = 0; i < NUM_LANES; i++)
      begin
        if (wr_en[i])
          lane_q[i] <= pick_0[i] ? fan_0 : fan_1;
      end
    end
  end

  assign out_0 = lane_q[0];
  assign out_1 = lane_q[1];
  assign out_2 = lane_q[2];
  assign out_3 = lane_q[3];
  assign out_4 = lane_q[4];
  assign out_5 = lane_q[5];
  assign out_6 = lane_q[6];
  assign out_7 = lane_q[7];

  // decode only picks a fan for a lane it is writing.
  a_pick_needs_write: assert property (@(posedge CLK) disable iff (!RST)
    (pick_0 & ~wr_en) == '0)
    else $error("fan choice set on a lane without write enable");

endmodule : trans_core

`default_nettype wire

// File: trans_decode.sv
`timescale 1ns/1ps
`default_nettype none

module trans_decode (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           instr_valid,
  input  trans_isa_pkg::trans_op_e       instr_op,
  input  logic [trans_pkg::LANE_W-1:0]    instr_a,
  input  logic [trans_pkg::LANE_W-1:0]    instr_b,
  input  logic [trans_pkg::NUM_LANES-1:0] instr_mask,
  input  logic [trans_pkg::DATA_W-1:0]    load_data,
  output logic [trans_pkg::SEL_W-1:0]     isel,
  output logic [trans_pkg::SEL_W-1:0]     osel,
  output logic                           load_en,
  output logic [trans_pkg::LANE_W-1:0]    load_lane,
  output logic [trans_pkg::DATA_W-1:0]    load_word
);

  import trans_pkg::*;
  import trans_isa_pkg::*;

  logic                 valid_q;
  trans_op_e            op_q;
  logic [LANE_W-1:0]    a_q;
  logic [LANE_W-1:0]    b_q;
  logic [NUM_LANES-1:0] mask_q;
  logic [DATA_W-1:0]    data_q;

  logic [SEL_W-1:0]     isel_d;
  logic [SEL_W-1:0]     osel_d;
  logic [SEL_W-1:0]     osel_q;

  // stage one control.
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      valid_q <= 1'b0;
      op_q    <= OP_NOP;
    end
    else
    begin
      valid_q <= instr_valid;
      op_q    <= instr_op;
    end
  end

  // stage one operands are only taken with a valid instruction.
  always_ff @(posedge CLK)
  begin
    if (instr_valid)
    begin
      a_q    <= instr_a;
      b_q    <= instr_b;
      mask_q <= instr_mask;
      data_q <= load_data;
    end
  end

  // expand the held instruction into both select words.
  always_comb
  begin
    isel_d = '0;
    osel_d = '0;
    if (valid_q)
    begin
      case (op_q)
        OP_MOVE:
        begin
          isel_d[a_q]                  = 1'b1;
          osel_d[NUM_LANES-1:0]        = mask_q;
          osel_d[SEL_W-1:NUM_LANES]    = mask_q;
        end
        OP_SWAP:
        begin
          // a == b would be a no-op, so leave selects clear.
          if (a_q != b_q)
          begin
            isel_d[a_q]                = 1'b1;
            isel_d[NUM_LANES + b_q]    = 1'b1;
            osel_d[a_q]                = 1'b1;
            osel_d[b_q]                = 1'b1;
            osel_d[NUM_LANES + b_q]    = 1'b1;
          end
        end
        OP_LOAD:
        begin
          // lane io swaps load_word into lane a's input.
          isel_d[a_q]                  = 1'b1;
          osel_d[a_q]                  = 1'b1;
          osel_d[NUM_LANES + a_q]      = 1'b1;
        end
        OP_MERGE:
        begin
          isel_d[NUM_LANES-1:0]        = mask_q;
          osel_d[a_q]                  = 1'b1;
          osel_d[NUM_LANES + a_q]      = 1'b1;
        end
        default:
        begin
          isel_d = '0;
          osel_d = '0;
        end
      endcase
    end
  end

  // stage two delays osel to match the fan capture.
  always_ff @(posedge CLK)
  begin
    if (!RST)
      osel_q <= '0;
    else
      osel_q <= osel_d;
  end

  assign isel      = isel_d;
  assign osel      = osel_q;
  assign load_en   = valid_q && (op_q == OP_LOAD);
  assign load_lane = a_q;
  assign load_word = data_q;

  // a write needs fans captured the cycle before; a merge of nothing writes zero.
  a_osel_after_isel: assert property (@(posedge CLK) disable iff (!RST)
    (osel != '0) |-> $past((isel != '0) || (op_q == OP_MERGE)))
    else $error("osel set without a preceding fan capture");

endmodule : trans_decode

`default_nettype wire

// File: trans_isa_pkg.sv
`default_nettype none

// transport instruction set.
package trans_isa_pkg;

  // opcode field width.
  localparam int OP_W = 3;

  // compact transport opcodes.
  typedef enum logic [OP_W-1:0] {
    OP_NOP   = 3'd0,
    OP_MOVE  = 3'd1,
    OP_SWAP  = 3'd2,
    OP_LOAD  = 3'd3,
    OP_MERGE = 3'd4
  } trans_op_e;

endpackage : trans_isa_pkg

`default_nettype wire

// File: trans_pkg.sv
`default_nettype none

// datapath sizes for the eight-lane transport unit.
package trans_pkg;

  // one 32-bit word per lane.
  localparam int NUM_LANES = 8;
  localparam int DATA_W    = 32;

  // lane index width for NUM_LANES lanes.
  localparam int LANE_W    = 3;

  // isel bits [7:0] enable lanes onto fan 0 and bits [15:8] onto fan 1.
  // osel bits [7:0] are lane write enables and bits [15:8] pick fan 0 when set.
  localparam int SEL_W     = 2 * NUM_LANES;

endpackage : trans_pkg

`default_nettype wire
